// ==== sd_defs.svh ====
// Shared constants for the microSD CMD-line bring-up
// Include in any file that needs clock, timeout or command values
`ifndef SD_DEFS_SVH
`define SD_DEFS_SVH

// SD_CLK timing
`define SD_CLK_DIV          4           // CLK cycles per SD_CLK half period
`define SD_POWERUP_CLOCKS   80          // Rising edges with CMD high before first command
`define SD_RESP_TIMEOUT     64          // Rising edges allowed for a response start bit

// Frame geometry
`define SD_FRAME_BITS       48          // Start bit through end bit
`define SD_CRC_PAYLOAD_BITS 40          // Start bit through argument

// Commands used during bring-up
`define SD_CMD0_INDEX       6'd0        // GO_IDLE_STATE
`define SD_CMD8_INDEX       6'd8        // SEND_IF_COND
`define SD_CMD55_INDEX      6'd55       // APP_CMD
`define SD_CMD8_ARG         32'h0000_01AA // VHS 2.7-3.6V plus check pattern

// CMD8 echo fields
`define SD_CHECK_PATTERN    8'hAA       // Argument bits 7:0
`define SD_VHS_3V3          4'h1        // Argument bits 11:8

`endif

// ==== sd_pkg.sv ====
// Types shared by the SD bring-up blocks
// Frame layout, link request/result structs and the FSM state encodings
`include "sd_defs.svh"

package sd_pkg;

    typedef logic [5:0]                        cmd_index_t;   // Command index field
    typedef logic [31:0]                       cmd_arg_t;     // Command argument
    typedef logic [6:0]                        crc7_t;        // CRC7 checksum
    typedef logic [`SD_CRC_PAYLOAD_BITS-1:0]   crc_payload_t; // Bits covered by CRC7

    // One CMD-line frame, MSB goes out first
    typedef struct packed {
        logic       start_bit;  // Always 0
        logic       dir_bit;    // 1 host to card, 0 card to host
        cmd_index_t index;
        cmd_arg_t   arg;
        crc7_t      crc;
        logic       end_bit;    // Always 1
    } sd_frame_t;

    typedef struct packed {
        sd_frame_t  frame;
        logic       expect_response; // Clear for CMD0
    } link_request_t;

    typedef struct packed {
        logic       timed_out;  // No start bit seen
        sd_frame_t  frame;      // Captured response
    } link_result_t;

    typedef enum logic [3:0] {
        SEQ_POWERUP, SEQ_BUILD, SEQ_CMD_CRC, SEQ_CMD_CRC_WAIT, SEQ_LINK, SEQ_LINK_WAIT,
        SEQ_RESP_CRC, SEQ_RESP_CRC_WAIT, SEQ_DONE, SEQ_FAILED
    } seq_state_t;

    typedef enum logic [2:0] {
        LINK_IDLE, LINK_SEND, LINK_RELEASE, LINK_WAIT_START, LINK_RECEIVE
    } link_state_t;

endpackage

// ==== sd_clock_gen.sv ====
// SD_CLK generator with edge strobes and power-up clock count
// Strobes lead the SD_CLK edge by one CLK cycle
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_clock_gen (
    input  logic CLK,
    input  logic reset,
    output logic SD_CLK,
    output logic sd_rise,
    output logic sd_fall,
    output logic powered_up
);

    localparam int DIV_W = $clog2(`SD_CLK_DIV);
    localparam int PWR_W = $clog2(`SD_POWERUP_CLOCKS);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SD_CLK_DIV - 1);
    localparam logic [PWR_W-1:0] PWR_LAST = PWR_W'(`SD_POWERUP_CLOCKS - 1);

    logic [DIV_W-1:0] div_cnt;  // Half-period counter
    logic [PWR_W-1:0] pwr_cnt;  // Rising edges seen so far

    assign sd_rise = (div_cnt == DIV_LAST) && !SD_CLK; // Toggle to high is next
    assign sd_fall = (div_cnt == DIV_LAST) && SD_CLK;  // Toggle to low is next

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            div_cnt    <= '0;
            SD_CLK     <= 1'b0;      // Start low, free running after this
            pwr_cnt    <= '0;
            powered_up <= 1'b0;
        end
        else
        begin
            if (div_cnt == DIV_LAST)
            begin
                div_cnt <= '0;
                SD_CLK  <= ~SD_CLK;
            end
            else
                div_cnt <= div_cnt + 1'b1;

            // Count rises until the card has had its power-up clocks
            if (sd_rise && !powered_up)
            begin
                if (pwr_cnt == PWR_LAST)
                    powered_up <= 1'b1; // Sticky until reset
                else
                    pwr_cnt <= pwr_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== sd_crc7.sv ====
// Bit-serial CRC7 engine, generator x^7 + x^3 + 1
// Takes one 40-bit payload per valid/ready transfer, pulses crc_done with the remainder
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_crc7 (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 crc_valid,
    output logic                 crc_ready,
    input  sd_pkg::crc_payload_t crc_payload,
    output logic                 crc_done,
    output sd_pkg::crc7_t        crc_value
);

    import sd_pkg::*;

    localparam int CNT_W = $clog2(`SD_CRC_PAYLOAD_BITS + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SD_CRC_PAYLOAD_BITS);
    localparam crc7_t CRC_TAPS = 7'h09;  // x^3 + 1, x^7 is the feedback

    crc_payload_t     data_sr;   // Payload, MSB shifts out first
    crc7_t            crc_q;     // Running remainder
    logic [CNT_W-1:0] bit_cnt;   // Bits consumed
    logic             busy;
    logic             feedback;

    assign crc_ready = !busy;                                  // One item in flight
    assign crc_value = crc_q;
    assign feedback  = crc_q[6] ^ data_sr[`SD_CRC_PAYLOAD_BITS-1]; // Outgoing vs incoming bit

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            bit_cnt  <= '0;
            crc_q    <= '0;
            crc_done <= 1'b0;
        end
        else
        begin
            crc_done <= 1'b0;
            if (crc_valid && crc_ready)
            begin
                data_sr <= crc_payload;  // Capture request
                crc_q   <= '0;
                bit_cnt <= '0;
                busy    <= 1'b1;
            end
            else if (busy)
            begin
                if (bit_cnt == CNT_LAST)
                begin
                    crc_done <= 1'b1;    // Remainder already in crc_q
                    busy     <= 1'b0;
                end
                else
                begin
                    crc_q   <= {crc_q[5:0], 1'b0} ^ (feedback ? CRC_TAPS : 7'h00);
                    data_sr <= data_sr << 1;
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== sd_cmd_link.sv ====
// CMD-line link: shifts a 48-bit frame out, releases the line, then
// waits for a response start bit and shifts 48 bits back in
// Outgoing bits change on sd_fall, incoming bits are sampled on sd_rise
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_cmd_link (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  sd_rise,
    input  logic                  sd_fall,
    input  logic                  link_valid,
    output logic                  link_ready,
    input  sd_pkg::link_request_t link_request,
    output logic                  result_valid,
    output sd_pkg::link_result_t  link_result,
    output logic                  cmd_drive,
    output logic                  cmd_enable,
    input  logic                  cmd_sense
);

    import sd_pkg::*;

    localparam int BIT_W = $clog2(`SD_FRAME_BITS);
    localparam int TO_W  = $clog2(`SD_RESP_TIMEOUT);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SD_FRAME_BITS - 1);
    localparam logic [TO_W-1:0]  TO_LAST  = TO_W'(`SD_RESP_TIMEOUT - 1);

    link_state_t              state;
    logic [`SD_FRAME_BITS-1:0] frame_sr;   // Shared TX/RX shift register
    logic [BIT_W-1:0]         bit_cnt;
    logic [TO_W-1:0]          timeout_cnt; // Rises since line release
    logic                     expect_q;    // Response wanted for this frame
    logic                     timed_out_q;

    assign link_ready  = (state == LINK_IDLE);
    assign link_result = '{timed_out: timed_out_q, frame: sd_frame_t'(frame_sr)};

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state        <= LINK_IDLE;
            cmd_drive    <= 1'b1;       // Idle level of CMD
            cmd_enable   <= 1'b0;
            result_valid <= 1'b0;
            bit_cnt      <= '0;
            timeout_cnt  <= '0;
        end
        else
        begin
            result_valid <= 1'b0;
            case (state)
                LINK_IDLE:
                begin
                    if (link_valid)
                    begin
                        frame_sr <= link_request.frame;
                        expect_q <= link_request.expect_response;
                        bit_cnt  <= '0;
                        state    <= LINK_SEND;
                    end
                end
                LINK_SEND:
                begin
                    if (sd_fall)
                    begin
                        cmd_drive  <= frame_sr[`SD_FRAME_BITS-1]; // MSB first
                        cmd_enable <= 1'b1;
                        frame_sr   <= frame_sr << 1;
                        bit_cnt    <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                            state <= LINK_RELEASE;     // End bit is on the line
                    end
                end
                LINK_RELEASE:
                begin
                    if (sd_fall)
                    begin
                        cmd_enable  <= 1'b0;  // Card owns the line now
                        cmd_drive   <= 1'b1;
                        timeout_cnt <= '0;
                        state       <= LINK_WAIT_START;
                    end
                end
                LINK_WAIT_START:
                begin
                    if (sd_rise)
                    begin
                        if (expect_q && !cmd_sense)
                        begin
                            frame_sr <= {frame_sr[`SD_FRAME_BITS-2:0], cmd_sense}; // Start bit
                            bit_cnt  <= BIT_W'(1);
                            state    <= LINK_RECEIVE;
                        end
                        else if (timeout_cnt == TO_LAST)
                        begin
                            timed_out_q  <= 1'b1;  // Normal outcome for CMD0
                            result_valid <= 1'b1;
                            state        <= LINK_IDLE;
                        end
                        else
                            timeout_cnt <= timeout_cnt + 1'b1;
                    end
                end
                LINK_RECEIVE:
                begin
                    if (sd_rise)
                    begin
                        frame_sr <= {frame_sr[`SD_FRAME_BITS-2:0], cmd_sense};
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST)
                        begin
                            timed_out_q  <= 1'b0;
                            result_valid <= 1'b1;  // Full frame in frame_sr next cycle
                            state        <= LINK_IDLE;
                        end
                    end
                end
                default: state <= LINK_IDLE;
            endcase
        end
    end

endmodule

// ==== sd_init_sequencer.sv ====
// Bring-up command sequencer: CMD0, CMD8, CMD55
// Builds each frame, fetches its CRC7, sends it through the link and checks the reply
// Ends in done after a good CMD55 response, or in failed on any bad response
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_init_sequencer (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  powered_up,
    output logic                  crc_valid,
    input  logic                  crc_ready,
    output sd_pkg::crc_payload_t  crc_payload,
    input  logic                  crc_done,
    input  sd_pkg::crc7_t         crc_value,
    output logic                  link_valid,
    input  logic                  link_ready,
    output sd_pkg::link_request_t link_request,
    input  logic                  result_valid,
    input  sd_pkg::link_result_t  link_result,
    output logic                  init_done,
    output logic                  init_error
);

    import sd_pkg::*;

    localparam int PAY_HI = `SD_FRAME_BITS - 1;
    localparam int PAY_LO = `SD_FRAME_BITS - `SD_CRC_PAYLOAD_BITS;

    seq_state_t state;
    cmd_index_t cur_index;   // Command in progress
    sd_frame_t  frame_q;     // Outgoing frame
    sd_frame_t  resp_q;      // Last response
    logic       echo_ok;     // CMD8 echo fields match

    // Response payload while checking a reply, otherwise the command payload
    assign crc_payload = (state == SEQ_RESP_CRC) ? resp_q[PAY_HI:PAY_LO] : frame_q[PAY_HI:PAY_LO];
    assign crc_valid   = (state == SEQ_CMD_CRC) || (state == SEQ_RESP_CRC);
    assign link_valid  = (state == SEQ_LINK);
    assign link_request = '{frame: frame_q, expect_response: (cur_index != `SD_CMD0_INDEX)};
    assign init_done   = (state == SEQ_DONE);
    assign init_error  = (state == SEQ_FAILED);

    assign echo_ok = (resp_q.arg[7:0] == `SD_CHECK_PATTERN) && (resp_q.arg[11:8] == `SD_VHS_3V3);

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            state     <= SEQ_POWERUP;
            cur_index <= `SD_CMD0_INDEX;
        end
        else
        begin
            case (state)
                SEQ_POWERUP:
                    if (powered_up)
                        state <= SEQ_BUILD;  // Power-up clocks are done
                SEQ_BUILD:
                begin
                    frame_q <= '{start_bit: 1'b0, dir_bit: 1'b1, index: cur_index,
                                 arg: (cur_index == `SD_CMD8_INDEX) ? `SD_CMD8_ARG : 32'h0,
                                 crc: 7'h00, end_bit: 1'b1};
                    state   <= SEQ_CMD_CRC;
                end
                SEQ_CMD_CRC:
                    if (crc_ready)
                        state <= SEQ_CMD_CRC_WAIT;
                SEQ_CMD_CRC_WAIT:
                begin
                    if (crc_done)
                    begin
                        frame_q.crc <= crc_value;  // Insert computed checksum
                        state       <= SEQ_LINK;
                    end
                end
                SEQ_LINK:
                    if (link_ready)
                        state <= SEQ_LINK_WAIT;
                SEQ_LINK_WAIT:
                begin
                    if (result_valid)
                    begin
                        resp_q <= link_result.frame;
                        if (cur_index == `SD_CMD0_INDEX)
                        begin
                            cur_index <= `SD_CMD8_INDEX;  // CMD0 never answers
                            state     <= SEQ_BUILD;
                        end
                        else if (link_result.timed_out || link_result.frame.index != cur_index)
                            state <= SEQ_FAILED;           // Missing reply or wrong index
                        else
                            state <= SEQ_RESP_CRC;
                    end
                end
                SEQ_RESP_CRC:
                    if (crc_ready)
                        state <= SEQ_RESP_CRC_WAIT;
                SEQ_RESP_CRC_WAIT:
                begin
                    if (crc_done)
                    begin
                        if (crc_value != resp_q.crc)
                            state <= SEQ_FAILED;
                        else if (cur_index == `SD_CMD8_INDEX)
                        begin
                            if (echo_ok)
                            begin
                                cur_index <= `SD_CMD55_INDEX;
                                state     <= SEQ_BUILD;
                            end
                            else
                                state <= SEQ_FAILED;  // Card rejected voltage or bad echo
                        end
                        else
                            state <= SEQ_DONE;        // Good CMD55 reply
                    end
                end
                SEQ_DONE:   state <= SEQ_DONE;
                SEQ_FAILED: state <= SEQ_FAILED;
                default:    state <= SEQ_FAILED;
            endcase
        end
    end

endmodule

// ==== sd_card_init.sv ====
// Top level of the microSD bring-up over the CMD line
// CMD pin is split into drive, enable and sense for a tristate-free model
`timescale 1ns/1ps

module sd_card_init (
    input  logic CLK,
    input  logic reset,
    output logic SD_CLK,
    output logic cmd_drive,
    output logic cmd_enable,
    input  logic cmd_sense,
    output logic init_done,
    output logic init_error
);

    import sd_pkg::*;

    logic          sd_rise;
    logic          sd_fall;
    logic          powered_up;
    logic          crc_valid;
    logic          crc_ready;
    crc_payload_t  crc_payload;
    logic          crc_done;
    crc7_t         crc_value;
    logic          link_valid;
    logic          link_ready;
    link_request_t link_request;
    logic          result_valid;
    link_result_t  link_result;

    sd_clock_gen sd_clock_gen_i (.CLK, .reset, .SD_CLK, .sd_rise, .sd_fall, .powered_up);

    sd_crc7 sd_crc7_i (.CLK, .reset, .crc_valid, .crc_ready, .crc_payload, .crc_done, .crc_value);

    sd_cmd_link sd_cmd_link_i (
        .CLK, .reset, .sd_rise, .sd_fall, .link_valid, .link_ready, .link_request,
        .result_valid, .link_result, .cmd_drive, .cmd_enable, .cmd_sense
    );

    sd_init_sequencer sd_init_sequencer_i (
        .CLK, .reset, .powered_up, .crc_valid, .crc_ready, .crc_payload, .crc_done,
        .crc_value, .link_valid, .link_ready, .link_request, .result_valid, .link_result,
        .init_done, .init_error
    );

endmodule

// ==== sd_card_init_checker.sv ====
// Protocol assertions for the SD bring-up top level
// Bound to sd_card_init from the testbench, sees the internal strobes
`timescale 1ns/1ps

module sd_card_init_checker (
    input logic CLK,
    input logic reset,
    input logic init_done,
    input logic init_error,
    input logic cmd_enable,
    input logic cmd_drive,
    input logic powered_up,
    input logic sd_fall
);

    // Done and failed are separate end states
    done_error_exclusive: assert property (@(posedge CLK) disable iff (reset)
        !(init_done && init_error))
        else $error("init_done and init_error high in the same cycle");

    // No command before the card has had its power-up clocks
    enable_after_powerup: assert property (@(posedge CLK) disable iff (reset)
        (cmd_enable && !$past(cmd_enable)) |-> powered_up)
        else $error("cmd_enable rose before powered_up");

    // CMD bits only change with SD_CLK falling
    drive_on_fall: assert property (@(posedge CLK) disable iff (reset)
        (cmd_drive != $past(cmd_drive)) |-> $past(sd_fall))
        else $error("cmd_drive changed outside an sd_fall cycle");

endmodule

// ==== sd_card_init_tb.sv ====
// Testbench for the microSD CMD-line bring-up
// Behavioural card model captures host frames and answers CMD8/CMD55 as each test sets up
`timescale 1ns/1ps
`include "sd_defs.svh"

module sd_card_init_tb;

    import sd_pkg::*;

    localparam int CYCLE_LIMIT   = 20000;  // Six tests take roughly 14k cycles
    localparam int REPLY_DELAY   = 2;      // SD_CLK falls between end bit and card reply
    localparam int MODE_GOOD     = 0;      // CMD8 reply variants
    localparam int MODE_BAD_CRC  = 1;
    localparam int MODE_SILENT   = 2;
    localparam int MODE_BAD_ECHO = 3;

    logic        CLK;
    logic        reset;
    logic        SD_CLK;
    logic        cmd_drive;
    logic        cmd_enable;
    logic        cmd_sense;
    logic        init_done;
    logic        init_error;
    logic        card_out;             // Card side of CMD, idles high
    logic        cmd_line;             // What both ends see on CMD
    logic        sd_clk_q;             // SD_CLK at previous negedge CLK
    logic [47:0] capture_sr;
    logic [47:0] reply_frame;
    logic        reply_pending;
    logic [47:0] host_frames[$];       // Every frame the host sent since reset
    int          capture_cnt;
    int          sd_rises;             // SD_CLK rising edges since reset
    int          reply_mode;
    int          bit_pos;
    int          error_count;
    int          tests_run;
    int          cycle_count;

    assign cmd_line  = cmd_enable ? cmd_drive : card_out;
    assign cmd_sense = cmd_line;

    sd_card_init sd_card_init_i (.CLK, .reset, .SD_CLK, .cmd_drive, .cmd_enable, .cmd_sense,
                                 .init_done, .init_error);

    bind sd_card_init sd_card_init_checker checker_i (
        .CLK, .reset, .init_done, .init_error, .cmd_enable, .cmd_drive, .powered_up, .sd_fall
    );

    always #5 CLK = ~CLK;              // 10 ns period

    always @(posedge CLK)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // CRC7, x^7 + x^3 + 1, MSB of payload first
    function automatic logic [6:0] crc7_calc(input logic [39:0] payload);
        logic [6:0] crc;
        logic       fb;
        begin
            crc = 7'h00;
            for (int k = 39; k >= 0; k--)
            begin
                fb  = crc[6] ^ payload[k];
                crc = {crc[5:0], 1'b0};
                if (fb)
                    crc = crc ^ 7'h09;     // x^3 + 1 taps
            end
            return crc;
        end
    endfunction

    function automatic logic [47:0] host_frame(input cmd_index_t index, input cmd_arg_t arg);
        return {1'b0, 1'b1, index, arg, crc7_calc({1'b0, 1'b1, index, arg}), 1'b1};
    endfunction

    function automatic logic [47:0] card_frame(input cmd_index_t index, input cmd_arg_t arg,
                                               input logic bad_crc);
        logic [6:0] crc;
        begin
            crc = crc7_calc({2'b00, index, arg});  // Direction bit 0 from card
            if (bad_crc)
                crc = ~crc;
            return {2'b00, index, arg, crc, 1'b1};
        end
    endfunction

    // Pick the answer for a captured host frame
    task queue_reply(input logic [47:0] frame);
        sd_frame_t f;
        begin
            f = frame;
            if (f.index == `SD_CMD8_INDEX && reply_mode != MODE_SILENT)
            begin
                reply_frame   = card_frame(`SD_CMD8_INDEX,
                                           (reply_mode == MODE_BAD_ECHO) ?
                                               32'h0000_0155 : `SD_CMD8_ARG,
                                           reply_mode == MODE_BAD_CRC);
                reply_pending = 1'b1;
            end
            else if (f.index == `SD_CMD55_INDEX)
            begin
                reply_frame   = card_frame(`SD_CMD55_INDEX, 32'h0000_0120, 1'b0); // Idle + APP_CMD
                reply_pending = 1'b1;
            end
        end
    endtask

    // Host frame capture on SD_CLK rises, seen from the stable negedge CLK
    always @(negedge CLK)
    begin
        if (SD_CLK && !sd_clk_q)
        begin
            sd_rises++;
            if (capture_cnt > 0)
            begin
                capture_sr = {capture_sr[46:0], cmd_line};
                capture_cnt++;
                if (capture_cnt == `SD_FRAME_BITS)
                begin
                    host_frames.push_back(capture_sr);
                    capture_cnt = 0;
                    queue_reply(capture_sr);
                end
            end
            else if (cmd_enable && !cmd_line)
            begin
                capture_sr  = '0;          // Start bit
                capture_cnt = 1;
            end
        end
        sd_clk_q = SD_CLK;
    end

    // Card reply, each bit changes after an SD_CLK fall
    always
    begin
        wait (reply_pending);
        reply_pending = 1'b0;
        repeat (REPLY_DELAY) @(negedge SD_CLK);
        for (bit_pos = `SD_FRAME_BITS - 1; bit_pos >= 0; bit_pos--)
        begin
            @(negedge SD_CLK);
            @(negedge CLK);
            card_out = reply_frame[bit_pos];
        end
        @(negedge SD_CLK);
        @(negedge CLK);
        card_out = 1'b1;                   // Back to idle
    end

    task apply_reset;
        begin
            @(negedge CLK);
            reset    = 1'b1;
            card_out = 1'b1;
            repeat (2) @(negedge CLK);
            reset         = 1'b0;
            reply_pending = 1'b0;          // SD_CLK held low here, model is quiet
            capture_cnt   = 0;
            sd_rises      = 0;
            host_frames.delete();
        end
    endtask

    task report_mismatch(input string test_name, input string what,
                         input logic [47:0] expected, input logic [47:0] actual);
        error_count++;
        $display("ERR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    endtask

    task report_failure(input string test_name, input string what);
        error_count++;
        $display("%s failed: %s", test_name, what);
    endtask

    task summarize_test(input string test_name, input int errs_before);
        tests_run++;
        $display("%s finished with %0d failed checks", test_name, error_count - errs_before);
    endtask

    task wait_frames(input int count);
        while (host_frames.size() < count)
            @(negedge CLK);
    endtask

    task wait_outcome;
        while (!init_done && !init_error)
            @(negedge CLK);
    endtask

    task verify_powerup;
        int errs_before;
        int clk_cycles;
        begin
            errs_before = error_count;
            reply_mode  = MODE_SILENT;
            apply_reset;
            @(posedge SD_CLK);
            @(negedge CLK);
            clk_cycles = 0;
            while (SD_CLK)                 // High half of one SD_CLK period
            begin
                clk_cycles++;
                @(negedge CLK);
            end
            while (!SD_CLK)                // Low half up to the next rise
            begin
                clk_cycles++;
                @(negedge CLK);
            end
            if (clk_cycles != 2 * `SD_CLK_DIV)
                report_mismatch("powerup", "SD_CLK period", 48'(2 * `SD_CLK_DIV),
                                48'(clk_cycles));
            while (!cmd_enable)
                @(negedge CLK);
            if (sd_rises < `SD_POWERUP_CLOCKS)
                report_failure("powerup", $sformatf("CMD driven after only %0d SD_CLK rises",
                                                    sd_rises));
            summarize_test("powerup", errs_before);
        end
    endtask

    task capture_cmd0_frame;
        int errs_before;
        begin
            errs_before = error_count;
            reply_mode  = MODE_SILENT;
            apply_reset;
            wait_frames(2);
            if (host_frames[0] !== {1'b0, 1'b1, 6'd0, 32'd0, 7'h4A, 1'b1})
                report_mismatch("cmd0_frame", "CMD0", {1'b0, 1'b1, 6'd0, 32'd0, 7'h4A, 1'b1},
                                host_frames[0]);
            if (host_frames[1] !== host_frame(`SD_CMD8_INDEX, `SD_CMD8_ARG))
                report_mismatch("cmd0_frame", "CMD8", host_frame(`SD_CMD8_INDEX, `SD_CMD8_ARG),
                                host_frames[1]);
            summarize_test("cmd0_frame", errs_before);
        end
    endtask

    task run_good_sequence;
        int errs_before;
        begin
            errs_before = error_count;
            reply_mode  = MODE_GOOD;
            apply_reset;
            wait_outcome;
            if (init_done !== 1'b1)
                report_mismatch("good_sequence", "init_done", 48'(1'b1), 48'(init_done));
            if (init_error !== 1'b0)
                report_mismatch("good_sequence", "init_error", 48'(1'b0), 48'(init_error));
            if (host_frames.size() != 3)
                report_mismatch("good_sequence", "frames", 48'(3), 48'(host_frames.size()));
            else if (host_frames[2] !== host_frame(`SD_CMD55_INDEX, 32'h0))
                report_mismatch("good_sequence", "CMD55", host_frame(`SD_CMD55_INDEX, 32'h0),
                                host_frames[2]);
            summarize_test("good_sequence", errs_before);
        end
    endtask

    // Shared by the three CMD8 failure cases
    task expect_cmd8_failure(input string test_name, input int mode);
        int errs_before;
        begin
            errs_before = error_count;
            reply_mode  = mode;
            apply_reset;
            wait_outcome;
            repeat (100) @(negedge CLK);   // Window for a stray CMD55
            if (init_error !== 1'b1)
                report_mismatch(test_name, "init_error", 48'(1'b1), 48'(init_error));
            if (init_done !== 1'b0)
                report_mismatch(test_name, "init_done", 48'(1'b0), 48'(init_done));
            if (host_frames.size() != 2 || cmd_enable)
                report_failure(test_name, "host kept sending after CMD8 failed");
            summarize_test(test_name, errs_before);
        end
    endtask

    initial
    begin
        CLK           = 1'b0;
        reset         = 1'b1;
        card_out      = 1'b1;
        sd_clk_q      = 1'b0;
        reply_pending = 1'b0;
        reply_mode    = MODE_SILENT;
        capture_cnt   = 0;
        sd_rises      = 0;
        error_count   = 0;
        tests_run     = 0;
        cycle_count   = 0;
        verify_powerup;
        capture_cmd0_frame;
        run_good_sequence;
        expect_cmd8_failure("bad_resp_crc", MODE_BAD_CRC);
        expect_cmd8_failure("missing_cmd8_resp", MODE_SILENT);
        expect_cmd8_failure("wrong_echo", MODE_BAD_ECHO);
        $display("Tests run: %0d, failed checks: %0d", tests_run, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
sd_pkg.sv
sd_clock_gen.sv
sd_crc7.sv
sd_cmd_link.sv
sd_init_sequencer.sv
sd_card_init.sv
sd_card_init_checker.sv
sd_card_init_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the SD bring-up testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f compile.f --top-module sd_card_init_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vsd_card_init_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
